/* Makefile */
VERILATOR ?= verilator
TOP       ?= DecodeStageTb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG) || (echo "Simulation ended early"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/ControlDecodeD.sv */
`timescale 1ns/100ps
module ControlDecodeD import DecodePkg::*; (
  input  InstrWord           instr,
  output InstructionTypes    instType,
  output InstructionSubTypes subType,
  output ControlSignals      ctrl
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       altBit;  // funct7[5], marks sub and sra

  assign opcode = instr.rType.opcode;
  assign funct3 = instr.rType.funct3;
  assign altBit = instr.rType.funct7[5];

  // ALU operation for the OP and OP_IMM groups
  function automatic AluOps aluFromFunct(input logic [2:0] f3, input logic alt,
                                         input logic isReg);
    AluOps op;
    case (f3)
      3'd0: op = (isReg && alt) ? ALU_SUB : ALU_ADD;  // addi never subtracts
      3'd1: op = ALU_SLL;
      3'd2: op = ALU_SLT;
      3'd3: op = ALU_SLTU;
      3'd4: op = ALU_XOR;
      3'd5: op = alt ? ALU_SRA : ALU_SRL;  // Shift type lives in imm[10] for srai
      3'd6: op = ALU_OR;
      3'd7: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    instType = ILLEGAL;
    subType  = NONE;
    ctrl     = '0;

    case (opcode)
      OPC_OP: begin
        instType      = REG_COMPUTATION;
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = aluFromFunct(funct3, altBit, 1'b1);
      end
      OPC_IMM: begin
        instType       = IMM_COMPUTATION;
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        ctrl.aluOp     = aluFromFunct(funct3, altBit, 1'b0);
      end
      OPC_LOAD: begin
        instType       = LOAD;
        ctrl.regWrite  = 1'b1;
        ctrl.memRead   = 1'b1;
        ctrl.aluSrcImm = 1'b1;  // Address is rs1 + imm
        ctrl.resultSrc = RESULT_MEM;
      end
      OPC_STORE: begin
        instType       = STORE;
        ctrl.memWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
      end
      OPC_BRANCH: begin
        instType    = BRANCH;
        ctrl.branch = 1'b1;
        // beq/bne compare by subtraction, the rest by set-less-than
        if (funct3[2]) begin
          ctrl.aluOp = funct3[1] ? ALU_SLTU : ALU_SLT;
        end else begin
          ctrl.aluOp = ALU_SUB;
        end
      end
      OPC_JAL: begin
        instType       = JUMP;
        subType        = JUMP_LINK;
        ctrl.jump      = 1'b1;
        ctrl.regWrite  = 1'b1;
        ctrl.resultSrc = RESULT_PC4;  // Link address
      end
      OPC_JALR: begin
        instType       = JUMP;
        subType        = JUMP_LINK_REG;
        ctrl.jump      = 1'b1;
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;  // Target is rs1 + imm
        ctrl.resultSrc = RESULT_PC4;
      end
      OPC_LUI: begin
        instType       = UPPER;
        subType        = LOAD_UPPER;
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        ctrl.aluOp     = ALU_PASSB;
      end
      OPC_AUIPC: begin
        instType       = UPPER;
        subType        = ADD_UPPER_PC;
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;  // Execute adds pc, not rs1
      end
      default: begin
        ctrl.illegal = 1'b1;  // SYSTEM, FENCE and unknown opcodes
      end
    endcase

    // An illegal word must never change architectural state
    assert (!ctrl.illegal || !(ctrl.regWrite || ctrl.memWrite || ctrl.jump))
      else $error("ControlDecodeD: illegal instruction with side effects");
  end

endmodule

/* hdl/DecodePkg.sv */
`include "decode_params.svh"

package DecodePkg;

  typedef enum logic [2:0] {
    REG_COMPUTATION,
    IMM_COMPUTATION,
    LOAD,
    STORE,
    BRANCH,
    JUMP,
    UPPER,
    ILLEGAL
  } InstructionTypes;

  typedef enum logic [2:0] {
    NONE,
    JUMP_LINK,      // jal
    JUMP_LINK_REG,  // jalr
    LOAD_UPPER,     // lui
    ADD_UPPER_PC    // auipc
  } InstructionSubTypes;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASSB  // Forward operand b, used by lui
  } AluOps;

  typedef enum logic [1:0] {
    RESULT_ALU,
    RESULT_MEM,
    RESULT_PC4
  } ResultSources;

  // RV32I major opcodes handled by this stage
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } RTypeFields;

  typedef struct packed {
    logic [11:0] imm11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } ITypeFields;

  typedef struct packed {
    logic [6:0] imm11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm4_0;
    logic [6:0] opcode;
  } STypeFields;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } BTypeFields;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } UTypeFields;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } JTypeFields;

  // One instruction word, six ways to read it
  typedef union packed {
    RTypeFields rType;
    ITypeFields iType;
    STypeFields sType;
    BTypeFields bType;
    UTypeFields uType;
    JTypeFields jType;
  } InstrWord;

  typedef struct packed {
    logic         regWrite;
    logic         memRead;
    logic         memWrite;
    logic         branch;
    logic         jump;
    logic         aluSrcImm;  // Operand b from imm instead of rs2
    logic         illegal;
    AluOps        aluOp;
    ResultSources resultSrc;
  } ControlSignals;

  typedef struct packed {
    logic              valid;
    logic [`XLEN-1:0]  pc;
    InstrWord          instr;
  } FetchBundle;

  typedef struct packed {
    logic                   writeEnable;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       data;
  } WritebackPort;

  typedef struct packed {
    logic                   valid;
    logic [`XLEN-1:0]       pc;
    ControlSignals          ctrl;
    InstructionTypes        instType;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic [2:0]             funct3;
    logic [`XLEN-1:0]       rs1Data;
    logic [`XLEN-1:0]       rs2Data;
    logic [`XLEN-1:0]       imm;
  } DecodeBundle;

endpackage

/* hdl/DecodeRegD.sv */
`timescale 1ns/100ps
`include "decode_params.svh"
module DecodeRegD import DecodePkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  logic             stall,
  input  logic             flush,
  input  FetchBundle       fetch,
  input  ControlSignals    ctrl,
  input  InstructionTypes  instType,
  input  logic [`XLEN-1:0] imm,
  input  logic [`XLEN-1:0] rs1Data,
  input  logic [`XLEN-1:0] rs2Data,
  output DecodeBundle      decoded
);

  DecodeBundle loadBundle;  // What the register takes on a normal advance

  always_comb begin
    loadBundle.valid    = fetch.valid;
    loadBundle.pc       = fetch.pc;
    loadBundle.ctrl     = fetch.valid ? ctrl : '0;  // No side effects from an empty slot
    loadBundle.instType = instType;
    loadBundle.rs1      = fetch.instr.rType.rs1;
    loadBundle.rs2      = fetch.instr.rType.rs2;
    loadBundle.rd       = fetch.instr.rType.rd;
    loadBundle.funct3   = fetch.instr.rType.funct3;
    loadBundle.rs1Data  = rs1Data;
    loadBundle.rs2Data  = rs2Data;
    loadBundle.imm      = imm;
  end

  // Reset, then flush, then stall, then load
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      decoded.valid <= 1'b0;
      decoded.ctrl  <= '0;  // Bubble
    end else if (!stall) begin
      decoded <= loadBundle;
    end
  end

  flushBubble: assert property (@(posedge clk) disable iff (reset)
    flush |=> !decoded.valid)
    else $error("DecodeRegD: valid bundle after flush");

endmodule

/* hdl/DecodeStageD.sv */
`timescale 1ns/100ps
`include "decode_params.svh"
module DecodeStageD import DecodePkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         stall,
  input  logic         flush,
  input  FetchBundle   fetch,
  input  WritebackPort wb,
  output DecodeBundle  decoded
);

  InstructionTypes    instType;
  InstructionSubTypes subType;
  ControlSignals      ctrl;
  logic [`XLEN-1:0]   imm;
  logic [`XLEN-1:0]   rs1Data;
  logic [`XLEN-1:0]   rs2Data;

  // Control and immediate path
  ControlDecodeD controlDecode_i (
    .instr    (fetch.instr),
    .instType (instType),
    .subType  (subType),
    .ctrl     (ctrl)
  );

  ImmDecodeD immDecode_i (
    .instType (instType),
    .subType  (subType),
    .instr    (fetch.instr),
    .immExt   (imm)
  );

  // Register path
  RegFileD regFile_i (
    .clk     (clk),
    .reset   (reset),
    .rs1     (fetch.instr.rType.rs1),
    .rs2     (fetch.instr.rType.rs2),
    .wb      (wb),
    .rs1Data (rs1Data),
    .rs2Data (rs2Data)
  );

  DecodeRegD decodeReg_i (
    .clk      (clk),
    .reset    (reset),
    .stall    (stall),
    .flush    (flush),
    .fetch    (fetch),
    .ctrl     (ctrl),
    .instType (instType),
    .imm      (imm),
    .rs1Data  (rs1Data),
    .rs2Data  (rs2Data),
    .decoded  (decoded)
  );

endmodule

/* hdl/ImmDecodeD.sv */
`timescale 1ns/100ps
`include "decode_params.svh"
module ImmDecodeD import DecodePkg::*; (
  input  InstructionTypes    instType,
  input  InstructionSubTypes subType,
  input  InstrWord           instr,
  output logic [`XLEN-1:0]   immExt
);

  logic [`XLEN-1:0] immI;
  logic [`XLEN-1:0] immS;
  logic [`XLEN-1:0] immB;
  logic [`XLEN-1:0] immU;
  logic [`XLEN-1:0] immJ;

  // Every signed format takes its sign from instruction bit 31
  assign immI = {{(`XLEN-12){instr.iType.imm11_0[11]}}, instr.iType.imm11_0};

  assign immS = {{(`XLEN-12){instr.sType.imm11_5[6]}}, instr.sType.imm11_5,
                 instr.sType.imm4_0};

  // Branch offset is halfword aligned
  assign immB = {{(`XLEN-12){instr.bType.imm12}}, instr.bType.imm11,
                 instr.bType.imm10_5, instr.bType.imm4_1, 1'b0};

  assign immU = {instr.uType.imm31_12, 12'b0};  // Low 12 bits zero

  assign immJ = {{(`XLEN-20){instr.jType.imm20}}, instr.jType.imm19_12,
                 instr.jType.imm11, instr.jType.imm10_1, 1'b0};

  always_comb begin
    case (instType)
      IMM_COMPUTATION: immExt = immI;
      LOAD:            immExt = immI;
      STORE:           immExt = immS;
      BRANCH:          immExt = immB;
      UPPER:           immExt = immU;
      JUMP: begin
        // jalr shares the I layout, jal has its own
        if (subType == JUMP_LINK_REG) begin
          immExt = immI;
        end else begin
          immExt = immJ;
        end
      end
      default:         immExt = '0;  // R-type and illegal carry no immediate
    endcase
  end

endmodule

/* hdl/RegFileD.sv */
`timescale 1ns/100ps
`include "decode_params.svh"
module RegFileD import DecodePkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`REG_ADDR_W-1:0] rs1,
  input  logic [`REG_ADDR_W-1:0] rs2,
  input  WritebackPort           wb,
  output logic [`XLEN-1:0]       rs1Data,
  output logic [`XLEN-1:0]       rs2Data
);

  localparam int NumRegs = 1 << `REG_ADDR_W;

  logic [`XLEN-1:0] regs [NumRegs];
  logic             wbHit;  // Writeback targets a real register

  assign wbHit = wb.writeEnable && (wb.rd != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wbHit) begin
      regs[wb.rd] <= wb.data;  // x0 never written
    end
  end

  // Read with write-to-read bypass and x0 forced to zero
  function automatic logic [`XLEN-1:0] readPort(input logic [`REG_ADDR_W-1:0] addr);
    logic [`XLEN-1:0] value;
    if (addr == '0) begin
      value = '0;
    end else if (wbHit && (wb.rd == addr)) begin
      value = wb.data;
    end else begin
      value = regs[addr];
    end
    return value;
  endfunction

  always_comb begin
    rs1Data = readPort(rs1);
    rs2Data = readPort(rs2);
  end

  x0ReadZero: assert property (@(posedge clk) disable iff (reset)
    ((rs1 == '0) |-> (rs1Data == '0)) and ((rs2 == '0) |-> (rs2Data == '0)))
    else $error("RegFileD: x0 read returned nonzero data");

endmodule

/* hdl/decode_params.svh */
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Data path and PC width
`define XLEN 32

// Register index width, 32 architectural registers
`define REG_ADDR_W 5

`endif

/* sources.f */
+incdir+hdl
hdl/DecodePkg.sv
hdl/ControlDecodeD.sv
hdl/ImmDecodeD.sv
hdl/RegFileD.sv
hdl/DecodeRegD.sv
hdl/DecodeStageD.sv
verif/DecodeStageTb.sv

/* verif/DecodeStageTb.sv */
`timescale 1ns/100ps
`include "decode_params.svh"
module DecodeStageTb import DecodePkg::*; ();

  localparam logic [2:0] ModeRun        = 3'd0;
  localparam logic [2:0] ModeStall      = 3'd1;
  localparam logic [2:0] ModeFlush      = 3'd2;
  localparam logic [2:0] ModeFlushStall = 3'd3;
  localparam logic [2:0] ModeBypass     = 3'd4;  // Writeback hits rs1 in the same cycle

  typedef struct packed {
    logic [31:0]     instr;
    logic [31:0]     pc;
    logic [31:0]     imm;
    InstructionTypes instType;
    logic [6:0]      flags;  // regWrite memWrite memRead branch jump aluSrcImm illegal
    ResultSources    resultSrc;
    AluOps           aluOp;  // Checked for computation rows only
    logic [2:0]      mode;
  } TestRow;

  logic         clk = 1'b0;
  logic         reset;
  logic         stall;
  logic         flush;
  FetchBundle   fetch;
  WritebackPort wb;
  DecodeBundle  decoded;

  TestRow           rows[$];
  TestRow           expRow;
  logic             expValid;
  logic [`XLEN-1:0] expRs1;
  logic [`XLEN-1:0] expRs2;
  logic [`XLEN-1:0] model [32];  // Reference register file
  logic [31:0]      randState = 32'h45c1_cc04;
  int               errors = 0;
  int               cycles = 0;

  DecodeStageD dut_i (
    .clk     (clk),
    .reset   (reset),
    .stall   (stall),
    .flush   (flush),
    .fetch   (fetch),
    .wb      (wb),
    .decoded (decoded)
  );

  always #4 clk = ~clk;  // 8 ns period

  // Reset, preload and four cycles per row plus slack
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > 10 + 32 + 4 * rows.size() + 50) begin
      $display("Timeout: the run did not finish within %0d cycles", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic addRow(input logic [31:0] instr, input logic [31:0] imm,
                        input InstructionTypes instType, input logic [6:0] flags,
                        input ResultSources resultSrc, input AluOps aluOp,
                        input logic [2:0] mode);
    TestRow row;
    row.instr     = instr;
    row.pc        = 32'h0000_1000 + 32'(4 * rows.size());
    row.imm       = imm;
    row.instType  = instType;
    row.flags     = flags;
    row.resultSrc = resultSrc;
    row.aluOp     = aluOp;
    row.mode      = mode;
    rows.push_back(row);
  endtask

  task automatic buildTable();
    // Word, immediate, type, flags, resultSrc, aluOp, mode
    addRow(32'hFFD08293, 32'hFFFFFFFD, IMM_COMPUTATION, 7'b1000010, RESULT_ALU, ALU_ADD, ModeRun);
    addRow(32'h403ADA13, 32'h00000403, IMM_COMPUTATION, 7'b1000010, RESULT_ALU, ALU_SRA, ModeRun);
    addRow(32'h01012303, 32'h00000010, LOAD, 7'b1010010, RESULT_MEM, ALU_ADD, ModeRun);
    addRow(32'hFE71A623, 32'hFFFFFFEC, STORE, 7'b0100010, RESULT_ALU, ALU_ADD, ModeRun);
    addRow(32'hFE520CE3, 32'hFFFFFFF8, BRANCH, 7'b0001000, RESULT_ALU, ALU_ADD, ModeRun);
    addRow(32'h344120EF, 32'h00012344, JUMP, 7'b1000100, RESULT_PC4, ALU_ADD, ModeRun);
    addRow(32'hFFC300E7, 32'hFFFFFFFC, JUMP, 7'b1000110, RESULT_PC4, ALU_ADD, ModeRun);
    addRow(32'hABCDE437, 32'hABCDE000, UPPER, 7'b1000010, RESULT_ALU, ALU_ADD, ModeRun);
    addRow(32'h00012497, 32'h00012000, UPPER, 7'b1000010, RESULT_ALU, ALU_ADD, ModeRun);
    // sub, sra, add of x0 and x0, then add with a bypassed rs1
    addRow(32'h40C58533, 32'h0, REG_COMPUTATION, 7'b1000000, RESULT_ALU, ALU_SUB, ModeRun);
    addRow(32'h40F756B3, 32'h0, REG_COMPUTATION, 7'b1000000, RESULT_ALU, ALU_SRA, ModeRun);
    addRow(32'h00000833, 32'h0, REG_COMPUTATION, 7'b1000000, RESULT_ALU, ALU_ADD, ModeRun);
    addRow(32'h013908B3, 32'h0, REG_COMPUTATION, 7'b1000000, RESULT_ALU, ALU_ADD, ModeBypass);
    addRow(32'h01012303, 32'h00000010, LOAD, 7'b1010010, RESULT_MEM, ALU_ADD, ModeStall);
    addRow(32'hFE71A623, 32'hFFFFFFEC, STORE, 7'b0100010, RESULT_ALU, ALU_ADD, ModeFlush);
    addRow(32'h0000007F, 32'h0, ILLEGAL, 7'b0000001, RESULT_ALU, ALU_ADD, ModeRun);
    addRow(32'h00000000, 32'h0, ILLEGAL, 7'b0000001, RESULT_ALU, ALU_ADD, ModeRun);
    // Flush with stall right after a valid bundle
    addRow(32'hABCDE437, 32'hABCDE000, UPPER, 7'b1000010, RESULT_ALU, ALU_ADD, ModeFlushStall);
  endtask

  task automatic reportMismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    errors++;
    $display("FAIL time %0t: %s expected %h, actual %h", $time, name, expected, actual);
  endtask

  task automatic checkIdle();
    if (decoded.valid !== 1'b0)
      reportMismatch("valid", 32'h0, 32'(decoded.valid));
    if (decoded.ctrl !== '0)
      reportMismatch("ctrl", 32'h0, 32'(decoded.ctrl));
  endtask

  task automatic checkOutputs();
    logic [6:0] flags;
    flags = {decoded.ctrl.regWrite, decoded.ctrl.memWrite, decoded.ctrl.memRead,
             decoded.ctrl.branch, decoded.ctrl.jump, decoded.ctrl.aluSrcImm,
             decoded.ctrl.illegal};
    if (decoded.valid !== expValid)
      reportMismatch("valid", 32'(expValid), 32'(decoded.valid));
    if (!expValid) begin
      if (decoded.ctrl !== '0)
        reportMismatch("ctrl", 32'h0, 32'(decoded.ctrl));
    end else begin
      if (decoded.pc !== expRow.pc)
        reportMismatch("pc", expRow.pc, decoded.pc);
      if (decoded.instType !== expRow.instType)
        reportMismatch("instType", 32'(expRow.instType), 32'(decoded.instType));
      if (flags !== expRow.flags)
        reportMismatch("ctrl flags", 32'(expRow.flags), 32'(flags));
      if (decoded.ctrl.resultSrc !== expRow.resultSrc)
        reportMismatch("resultSrc", 32'(expRow.resultSrc), 32'(decoded.ctrl.resultSrc));
      if (decoded.imm !== expRow.imm)
        reportMismatch("imm", expRow.imm, decoded.imm);
      if (decoded.rd !== expRow.instr[11:7])
        reportMismatch("rd", 32'(expRow.instr[11:7]), 32'(decoded.rd));
      if (decoded.rs1 !== expRow.instr[19:15])
        reportMismatch("rs1", 32'(expRow.instr[19:15]), 32'(decoded.rs1));
      if (decoded.rs2 !== expRow.instr[24:20])
        reportMismatch("rs2", 32'(expRow.instr[24:20]), 32'(decoded.rs2));
      if (decoded.funct3 !== expRow.instr[14:12])
        reportMismatch("funct3", 32'(expRow.instr[14:12]), 32'(decoded.funct3));
      if (decoded.rs1Data !== expRs1)
        reportMismatch("rs1Data", expRs1, decoded.rs1Data);
      if (decoded.rs2Data !== expRs2)
        reportMismatch("rs2Data", expRs2, decoded.rs2Data);
      if ((expRow.instType inside {REG_COMPUTATION, IMM_COMPUTATION}) &&
          (decoded.ctrl.aluOp !== expRow.aluOp))
        reportMismatch("aluOp", 32'(expRow.aluOp), 32'(decoded.ctrl.aluOp));
    end
  endtask

  initial begin
    TestRow row;
    reset    = 1'b1;
    stall    = 1'b0;
    flush    = 1'b0;
    fetch    = '0;
    wb       = '0;
    expValid = 1'b0;
    expRow   = '0;
    expRs1   = '0;
    expRs2   = '0;
    foreach (model[i]) begin
      model[i] = '0;
    end
    buildTable();

    repeat (10) begin
      @(negedge clk);
      checkIdle();
    end
    reset = 1'b0;

    // Fill every register through writeback including x0
    for (int r = 0; r < 32; r++) begin
      randState      = xorshift(randState);
      wb.writeEnable = 1'b1;
      wb.rd          = r[4:0];
      wb.data        = randState;
      if (r != 0) begin
        model[r] = randState;
      end
      @(negedge clk);
      if (r == 0) begin
        checkIdle();  // First cycle out of reset
      end
    end
    wb.writeEnable = 1'b0;

    foreach (rows[i]) begin
      row         = rows[i];
      fetch.valid = 1'b1;
      fetch.pc    = row.pc;
      fetch.instr = row.instr;
      stall       = row.mode inside {ModeStall, ModeFlushStall};
      flush       = row.mode inside {ModeFlush, ModeFlushStall};
      wb.writeEnable = 1'b0;
      if (row.mode == ModeBypass) begin
        randState = xorshift(randState);
        wb        = {1'b1, row.instr[19:15], randState};
        model[row.instr[19:15]] = randState;  // Read sees the new value
      end
      if (flush) begin
        expValid = 1'b0;
      end else if (!stall) begin
        expValid = 1'b1;
        expRow   = row;
        expRs1   = model[row.instr[19:15]];
        expRs2   = model[row.instr[24:20]];
      end
      @(negedge clk);
      checkOutputs();
    end

    $display("Run complete: %0d rows, %0d errors", rows.size(), errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
